// File: hdl/dmaPkg.sv
package dmaPkg;

  // datapath widths
  localparam int dataWidth = 8;
  localparam int addrWidth = 16;
  localparam int channels  = 4;
  localparam int chanWidth = 2;

  // register codes seen on addrIn
  // codes 0 to 7 are channel registers, bit 0 picks count over address
  localparam logic [3:0] regCodeCommand       = 4'd8;
  localparam logic [3:0] regCodeStatus        = 4'd8;
  localparam logic [3:0] regCodeMode          = 4'd11;
  localparam logic [3:0] regCodeClearFlipFlop = 4'd12;

  // command register
  localparam int cmdDisableBit = 2;

  // mode register fields, bits 1:0 of the written byte carry the channel
  localparam int modeTypeLsb      = 2;
  localparam int modeAutoInitBit  = 4;
  localparam int modeDecrementBit = 5;

  // transfer types, zero is verify and moves no data
  localparam logic [1:0] typeWrite = 2'd1;
  localparam logic [1:0] typeRead  = 2'd2;

  // timing FSM states
  localparam int stateWidth = 3;
  localparam logic [stateWidth-1:0] stateIdle     = 3'd0;
  localparam logic [stateWidth-1:0] stateRequest  = 3'd1;
  localparam logic [stateWidth-1:0] stateLoad     = 3'd2;
  localparam logic [stateWidth-1:0] stateTransfer = 3'd3;
  localparam logic [stateWidth-1:0] stateUpdate   = 3'd4;

endpackage

// File: hdl/dmaPortDecode.sv
`timescale 1ns/10ps

module dmaPortDecode
(
  input  logic       busIf,
  input  logic       csN,
  input  logic       iorN,
  input  logic       iowN,
  input  logic       hlda,
  input  logic [3:0] addrIn,
  output logic       ldChannelReg,
  output logic       rdChannelReg,
  output logic       ldCommand,
  output logic       ldMode,
  output logic       rdStatus,
  output logic       clearFlipFlop
);

  import dmaPkg::*;

  logic hldaQ;
  logic programAllowed;
  logic cpuWrite;
  logic cpuRead;
  logic channelCode;

  // hlda from the previous clock, keeps the CPU out for one turnaround cycle
  always_ff @(posedge busIf)
  begin
    hldaQ <= hlda;
  end

  // the CPU owns the registers only while the bus is not granted
  assign programAllowed = ~hlda & ~hldaQ;

  assign cpuWrite = programAllowed & ~csN & ~iowN & iorN;
  assign cpuRead  = programAllowed & ~csN & ~iorN & iowN;

  // codes 0 to 7 reach the address and count registers
  assign channelCode = ~addrIn[3];

  assign ldChannelReg = cpuWrite & channelCode;
  assign rdChannelReg = cpuRead & channelCode;

  // command and status share a code, direction tells them apart
  assign ldCommand = cpuWrite & (addrIn == regCodeCommand);
  assign rdStatus  = cpuRead & (addrIn == regCodeStatus);

  assign ldMode = cpuWrite & (addrIn == regCodeMode);

  // data on this write is ignored
  assign clearFlipFlop = cpuWrite & (addrIn == regCodeClearFlipFlop);

endmodule

// File: hdl/dmaChannelRegisters.sv
`timescale 1ns/10ps

module dmaChannelRegisters
(
  input  logic                          busIf,
  input  logic                          reset,
  input  logic                          ldChannelReg,
  input  logic                          rdChannelReg,
  input  logic                          clearFlipFlop,
  input  logic [3:0]                    addrIn,
  input  logic [dmaPkg::dataWidth-1:0]  dataIn,
  input  logic                          writeBack,
  input  logic                          reloadChannel,
  input  logic [dmaPkg::chanWidth-1:0]  activeChannel,
  input  logic [dmaPkg::addrWidth-1:0]  tempAddress,
  input  logic [dmaPkg::addrWidth-1:0]  tempCount,
  output logic [dmaPkg::dataWidth-1:0]  regReadData,
  output logic [dmaPkg::addrWidth-1:0]  currentAddress,
  output logic [dmaPkg::addrWidth-1:0]  currentCount
);

  import dmaPkg::*;

  logic [addrWidth-1:0] baseAddr  [channels];
  logic [addrWidth-1:0] baseCount [channels];
  logic [addrWidth-1:0] curAddr   [channels];
  logic [addrWidth-1:0] curCount  [channels];

  // byte pointer, 0 selects the low byte
  logic                 flipFlop;
  logic [chanWidth-1:0] regChannel;
  logic                 countSelect;
  logic [addrWidth-1:0] readWord;
  int                   byteLsb;

  assign regChannel  = addrIn[chanWidth:1];
  assign countSelect = addrIn[0];
  assign byteLsb     = flipFlop ? dataWidth : 0;

  // pointer toggles on every channel register access
  always_ff @(posedge busIf)
  begin
    if (reset || clearFlipFlop)
      flipFlop <= 1'b0;
    else if (ldChannelReg || rdChannelReg)
      flipFlop <= ~flipFlop;
  end

  // base copies change only from the CPU
  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      for (int i = 0; i < channels; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
      end
    end
    else if (ldChannelReg)
    begin
      if (countSelect)
        baseCount[regChannel][byteLsb +: dataWidth] <= dataIn;
      else
        baseAddr[regChannel][byteLsb +: dataWidth] <= dataIn;
    end
  end

  // current copies follow the CPU and then the transfers
  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      for (int i = 0; i < channels; i++)
      begin
        curAddr[i]  <= '0;
        curCount[i] <= '0;
      end
    end
    else if (ldChannelReg)
    begin
      if (countSelect)
        curCount[regChannel][byteLsb +: dataWidth] <= dataIn;
      else
        curAddr[regChannel][byteLsb +: dataWidth] <= dataIn;
    end
    else if (reloadChannel)
    begin
      // autoinit at terminal count
      curAddr[activeChannel]  <= baseAddr[activeChannel];
      curCount[activeChannel] <= baseCount[activeChannel];
    end
    else if (writeBack)
    begin
      curAddr[activeChannel]  <= tempAddress;
      curCount[activeChannel] <= tempCount;
    end
  end

  // readback always shows the current copy
  assign readWord    = countSelect ? curCount[regChannel] : curAddr[regChannel];
  assign regReadData = readWord[byteLsb +: dataWidth];

  assign currentAddress = curAddr[activeChannel];
  assign currentCount   = curCount[activeChannel];

endmodule

// File: hdl/dmaModeStatus.sv
`timescale 1ns/10ps

module dmaModeStatus
(
  input  logic                          busIf,
  input  logic                          reset,
  input  logic                          ldCommand,
  input  logic                          ldMode,
  input  logic                          rdStatus,
  input  logic [dmaPkg::dataWidth-1:0]  dataIn,
  input  logic [dmaPkg::channels-1:0]   dreq,
  input  logic                          eop,
  input  logic [dmaPkg::chanWidth-1:0]  activeChannel,
  output logic                          controllerDisabled,
  output logic [1:0]                    activeType,
  output logic                          activeDecrement,
  output logic                          activeAutoInit,
  output logic [dmaPkg::dataWidth-1:0]  statusByte
);

  import dmaPkg::*;

  // only type, autoinit and decrement are kept per channel
  logic [modeDecrementBit:modeTypeLsb] modeField [channels];
  logic [modeDecrementBit:modeTypeLsb] activeMode;
  logic [channels-1:0]                 tcFlags;

  // the other command bits have no function here
  always_ff @(posedge busIf)
  begin
    if (reset)
      controllerDisabled <= 1'b0;
    else if (ldCommand)
      controllerDisabled <= dataIn[cmdDisableBit];
  end

  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      for (int i = 0; i < channels; i++)
        modeField[i] <= '0;
    end
    else if (ldMode)
      modeField[dataIn[chanWidth-1:0]] <= dataIn[modeDecrementBit:modeTypeLsb];
  end

  assign activeMode      = modeField[activeChannel];
  assign activeType      = activeMode[modeTypeLsb+1:modeTypeLsb];
  assign activeAutoInit  = activeMode[modeAutoInitBit];
  assign activeDecrement = activeMode[modeDecrementBit];

  // sticky TC bits, a read clears them but a new TC in the same cycle wins
  always_ff @(posedge busIf)
  begin
    if (reset)
      tcFlags <= '0;
    else
    begin
      if (rdStatus)
        tcFlags <= '0;
      if (eop)
        tcFlags[activeChannel] <= 1'b1;
    end
  end

  // request bits are live, not latched
  assign statusByte = {dreq, tcFlags};

endmodule

// File: hdl/dmaTimingFsm.sv
`timescale 1ns/10ps

module dmaTimingFsm
(
  input  logic                          busIf,
  input  logic                          reset,
  input  logic [dmaPkg::channels-1:0]   dreq,
  input  logic                          hlda,
  input  logic                          controllerDisabled,
  input  logic [1:0]                    activeType,
  input  logic                          activeAutoInit,
  input  logic                          terminalCount,
  output logic                          hrq,
  output logic [dmaPkg::channels-1:0]   dack,
  output logic                          memrN,
  output logic                          memwN,
  output logic                          eop,
  output logic                          loadCount,
  output logic                          stepCount,
  output logic                          writeBack,
  output logic                          reloadChannel,
  output logic [dmaPkg::chanWidth-1:0]  activeChannel
);

  import dmaPkg::*;

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [channels-1:0]   requests;
  logic [chanWidth-1:0]  winner;
  logic                  inTransfer;

  assign requests = controllerDisabled ? '0 : dreq;

  // fixed priority, channel 0 wins
  always_comb
  begin
    winner = '0;
    for (int i = channels - 1; i >= 0; i--)
    begin
      if (requests[i])
        winner = i[chanWidth-1:0];
    end
  end

  always_comb
  begin
    nextState = state;
    case (state)
      stateIdle:     if (|requests) nextState = stateRequest;
      // wait for the bus grant as long as it takes
      stateRequest:  if (hlda) nextState = stateLoad;
      stateLoad:     nextState = stateTransfer;
      stateTransfer: nextState = stateUpdate;
      stateUpdate:   nextState = stateIdle;
      default:       nextState = stateIdle;
    endcase
  end

  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      state         <= stateIdle;
      activeChannel <= '0;
    end
    else
    begin
      state <= nextState;
      // channel is frozen once arbitration is won
      if (state == stateIdle && |requests)
        activeChannel <= winner;
    end
  end

  assign inTransfer = (state == stateTransfer);

  assign hrq   = (state != stateIdle);
  assign dack  = inTransfer ? (channels'(1) << activeChannel) : '0;
  assign memwN = ~(inTransfer && activeType == typeWrite);
  assign memrN = ~(inTransfer && activeType == typeRead);

  assign loadCount     = (state == stateLoad);
  assign stepCount     = (state == stateUpdate);
  assign writeBack     = (state == stateUpdate);
  assign eop           = (state == stateUpdate) && terminalCount;
  assign reloadChannel = eop && activeAutoInit;

endmodule

// File: hdl/dmaTransferCounter.sv
`timescale 1ns/10ps

module dmaTransferCounter
(
  input  logic                          busIf,
  input  logic                          reset,
  input  logic                          loadCount,
  input  logic                          stepCount,
  input  logic                          activeDecrement,
  input  logic [dmaPkg::addrWidth-1:0]  currentAddress,
  input  logic [dmaPkg::addrWidth-1:0]  currentCount,
  output logic [dmaPkg::addrWidth-1:0]  tempAddress,
  output logic [dmaPkg::addrWidth-1:0]  tempCount,
  output logic                          terminalCount
);

  import dmaPkg::*;

  logic [addrWidth-1:0] workAddress;
  logic [addrWidth-1:0] workCount;
  logic [addrWidth-1:0] nextAddress;
  logic [addrWidth-1:0] nextCount;

  assign nextAddress = activeDecrement ? workAddress - addrWidth'(1)
                                       : workAddress + addrWidth'(1);
  // count wraps to FFFF on the last word
  assign nextCount   = workCount - addrWidth'(1);

  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      workAddress <= '0;
      workCount   <= '0;
    end
    else if (loadCount)
    begin
      workAddress <= currentAddress;
      workCount   <= currentCount;
    end
    else if (stepCount)
    begin
      workAddress <= nextAddress;
      workCount   <= nextCount;
    end
  end

  // during the step cycle the stepped values go out for write back
  assign tempAddress = stepCount ? nextAddress : workAddress;
  assign tempCount   = stepCount ? nextCount : workCount;

  // judged on the count before the step
  assign terminalCount = (workCount == '0);

endmodule

// File: hdl/dmaController.sv
`timescale 1ns/10ps

module dmaController
(
  input  logic                          busIf,
  input  logic                          reset,
  input  logic                          csN,
  input  logic                          iorN,
  input  logic                          iowN,
  input  logic [3:0]                    addrIn,
  input  logic [dmaPkg::dataWidth-1:0]  dataIn,
  input  logic [dmaPkg::channels-1:0]   dreq,
  input  logic                          hlda,
  output logic [dmaPkg::dataWidth-1:0]  dataOut,
  output logic                          hrq,
  output logic [dmaPkg::channels-1:0]   dack,
  output logic [dmaPkg::addrWidth-1:0]  memAddr,
  output logic                          memrN,
  output logic                          memwN,
  output logic                          eop
);

  import dmaPkg::*;

  // decoder strobes
  logic ldChannelReg;
  logic rdChannelReg;
  logic ldCommand;
  logic ldMode;
  logic rdStatus;
  logic clearFlipFlop;

  // transfer control
  logic                 loadCount;
  logic                 stepCount;
  logic                 writeBack;
  logic                 reloadChannel;
  logic                 terminalCount;
  logic [chanWidth-1:0] activeChannel;

  // mode and status
  logic                 controllerDisabled;
  logic [1:0]           activeType;
  logic                 activeDecrement;
  logic                 activeAutoInit;
  logic [dataWidth-1:0] statusByte;

  // register data paths
  logic [dataWidth-1:0] regReadData;
  logic [addrWidth-1:0] currentAddress;
  logic [addrWidth-1:0] currentCount;
  logic [addrWidth-1:0] tempAddress;
  logic [addrWidth-1:0] tempCount;

  dmaPortDecode portDecode (.*);

  dmaChannelRegisters channelRegisters (.*);

  dmaModeStatus modeStatus (.*);

  dmaTimingFsm timingFsm (.*);

  dmaTransferCounter transferCounter (.*);

  assign dataOut = rdStatus ? statusByte : regReadData;
  assign memAddr = tempAddress;

endmodule

// File: bench/dmaTbTasks.svh
`ifndef dmaTbTasksSvh
`define dmaTbTasksSvh

// one CPU write with the strobes low for a single clock
task automatic cpuWrite(input logic [3:0] code, input logic [dataWidth-1:0] value);
  @(posedge busIf);
  csN    <= 1'b0;
  iowN   <= 1'b0;
  addrIn <= code;
  dataIn <= value;
  @(posedge busIf);
  csN  <= 1'b1;
  iowN <= 1'b1;
endtask

// dataOut is taken half way through the read clock
task automatic cpuRead(input logic [3:0] code, output logic [dataWidth-1:0] value);
  @(posedge busIf);
  csN    <= 1'b0;
  iorN   <= 1'b0;
  addrIn <= code;
  @(negedge busIf);
  value = dataOut;
  @(posedge busIf);
  csN  <= 1'b1;
  iorN <= 1'b1;
endtask

task automatic writeChannelWord(input int chan, input logic isCount,
                                input logic [addrWidth-1:0] word);
  cpuWrite(regCodeClearFlipFlop, 8'h00);
  cpuWrite(4'(chan * 2 + isCount), word[7:0]);
  cpuWrite(4'(chan * 2 + isCount), word[15:8]);
endtask

task automatic readChannelWord(input int chan, input logic isCount,
                               output logic [addrWidth-1:0] word);
  logic [dataWidth-1:0] lowByte;
  logic [dataWidth-1:0] highByte;
  cpuWrite(regCodeClearFlipFlop, 8'h00);
  cpuRead(4'(chan * 2 + isCount), lowByte);
  cpuRead(4'(chan * 2 + isCount), highByte);
  word = {highByte, lowByte};
endtask

task automatic reportMismatch(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
  $display("Error %s: expected %h, got %h", name, expected, got);
  errorCount++;
endtask

task automatic reportCycles(input string what, input int got, input int expected);
  $display("%s took %0d clock edges where %0d were expected", what, got, expected);
  errorCount++;
endtask

function automatic logic [7:0] modeByte(input int chan, input logic [1:0] kind,
                                        input logic autoInit, input logic decrement);
  logic [7:0] value;
  value = 8'(chan);
  value[modeTypeLsb +: 2]  = kind;
  value[modeAutoInitBit]   = autoInit;
  value[modeDecrementBit]  = decrement;
  return value;
endfunction

// mode, random address and the given count
task automatic programChannel(input int chan, input logic [7:0] mode,
                              input logic [addrWidth-1:0] count);
  modelAddr[chan]  = 16'($random(seed));
  modelCount[chan] = count;
  cpuWrite(regCodeMode, mode);
  writeChannelWord(chan, 1'b0, modelAddr[chan]);
  writeChannelWord(chan, 1'b1, count);
endtask

task automatic expectChannel(input int chan);
  logic [addrWidth-1:0] word;
  readChannelWord(chan, 1'b0, word);
  if (word !== modelAddr[chan])
    reportMismatch($sformatf("dataOut, channel %0d address", chan), word, modelAddr[chan]);
  readChannelWord(chan, 1'b1, word);
  if (word !== modelCount[chan])
    reportMismatch($sformatf("dataOut, channel %0d count", chan), word, modelCount[chan]);
endtask

// request, grant on hrq, and watch the pins until hrq falls
task automatic runTransfer(input logic [channels-1:0] request);
  int waited;
  int edges;
  waited          = 0;
  edges           = 0;
  strobeCycles    = 0;
  memStrobeCycles = 0;
  eopCycles       = 0;
  grantToStrobe   = -1;
  seenDack        = '0;
  seenAddr        = '0;
  seenMemrN       = 1'b1;
  seenMemwN       = 1'b1;
  @(posedge busIf);
  dreq <= request;
  @(negedge busIf);
  while (!hrq && waited < 20)
  begin
    @(negedge busIf);
    waited++;
  end
  if (!hrq)
  begin
    $display("hrq never rose for request %b", request);
    errorCount++;
  end
  else
  begin
    @(posedge busIf);
    hlda <= 1'b1;
    // edge 1 is the one that samples hlda
    while (hrq && edges < 20)
    begin
      @(posedge busIf);
      edges++;
      // the device lets go of its request once acknowledged
      if (strobeCycles > 0)
        dreq <= dreq & ~seenDack;
      @(negedge busIf);
      if (dack != '0)
      begin
        if (strobeCycles == 0)
        begin
          grantToStrobe = edges;
          seenDack      = dack;
          seenAddr      = memAddr;
          seenMemrN     = memrN;
          seenMemwN     = memwN;
        end
        strobeCycles++;
      end
      if (!memrN || !memwN)
        memStrobeCycles++;
      if (eop)
        eopCycles++;
    end
    if (hrq)
    begin
      $display("hrq stayed high for 20 cycles after the grant");
      errorCount++;
    end
    strobeToRelease = edges - grantToStrobe;
    @(posedge busIf);
    hlda <= 1'b0;
    // the decoder keeps the CPU out one more cycle
    repeat (2) @(posedge busIf);
  end
endtask

task automatic finishTest(input string name);
  if (errorCount == errorsBeforeTest)
  begin
    $display("%s: ok", name);
    testsPassed++;
  end
  else
  begin
    $display("%s: %0d errors", name, errorCount - errorsBeforeTest);
    testsFailed++;
  end
endtask

task automatic registerReadback();
  errorsBeforeTest = errorCount;
  for (int ch = 0; ch < channels; ch++)
    programChannel(ch, modeByte(ch, 2'b00, 1'b0, 1'b0), 16'($random(seed)));
  for (int ch = 0; ch < channels; ch++)
    expectChannel(ch);
  // a write during a bus grant must be dropped
  @(posedge busIf);
  hlda <= 1'b1;
  cpuWrite(4'd0, ~modelAddr[0][7:0]);
  @(posedge busIf);
  hlda <= 1'b0;
  repeat (2) @(posedge busIf);
  expectChannel(0);
  finishTest("register programming and readback");
endtask

task automatic bytePointerClear();
  logic [dataWidth-1:0] firstByte;
  logic [dataWidth-1:0] secondByte;
  errorsBeforeTest = errorCount;
  firstByte  = 8'($random(seed));
  secondByte = 8'($random(seed));
  cpuWrite(regCodeClearFlipFlop, 8'h00);
  cpuWrite(4'd2, firstByte);
  cpuWrite(regCodeClearFlipFlop, 8'h00);
  cpuWrite(4'd2, secondByte);
  modelAddr[1][7:0] = secondByte;
  expectChannel(1);
  finishTest("byte pointer clear");
endtask

task automatic transferTiming();
  errorsBeforeTest = errorCount;
  programChannel(2, modeByte(2, typeWrite, 1'b0, 1'b0), 16'($random(seed)) | 16'h0001);
  runTransfer(4'b0100);
  if (grantToStrobe != 2)
    reportCycles("hlda sample to strobe", grantToStrobe, 2);
  if (strobeCycles != 1)
    reportCycles("strobe", strobeCycles, 1);
  if (memStrobeCycles != 1)
    reportCycles("memory strobe", memStrobeCycles, 1);
  if (strobeToRelease != 2)
    reportCycles("strobe to hrq fall", strobeToRelease, 2);
  if (eopCycles != 0)
    reportCycles("eop without terminal count", eopCycles, 0);
  if (seenDack !== 4'b0100)
    reportMismatch("dack", 16'(seenDack), 16'h0004);
  if (seenMemwN !== 1'b0)
    reportMismatch("memwN", 16'(seenMemwN), 16'h0000);
  if (seenMemrN !== 1'b1)
    reportMismatch("memrN", 16'(seenMemrN), 16'h0001);
  if (seenAddr !== modelAddr[2])
    reportMismatch("memAddr", seenAddr, modelAddr[2]);
  modelAddr[2]  = modelAddr[2] + 16'd1;
  modelCount[2] = modelCount[2] - 16'd1;
  expectChannel(2);
  finishTest("transfer timing and address");
endtask

task automatic priorityAndDecrement();
  errorsBeforeTest = errorCount;
  programChannel(1, modeByte(1, typeWrite, 1'b0, 1'b0), 16'($random(seed)) | 16'h0001);
  programChannel(3, modeByte(3, typeRead, 1'b0, 1'b1), 16'($random(seed)) | 16'h0001);
  runTransfer(4'b1010);
  if (seenDack !== 4'b0010)
    reportMismatch("dack", 16'(seenDack), 16'h0002);
  if (seenAddr !== modelAddr[1])
    reportMismatch("memAddr", seenAddr, modelAddr[1]);
  // channel 3 is still requesting
  runTransfer(4'b1000);
  if (seenDack !== 4'b1000)
    reportMismatch("dack", 16'(seenDack), 16'h0008);
  if (seenMemrN !== 1'b0)
    reportMismatch("memrN", 16'(seenMemrN), 16'h0000);
  if (seenMemwN !== 1'b1)
    reportMismatch("memwN", 16'(seenMemwN), 16'h0001);
  if (memStrobeCycles != 1)
    reportCycles("memory strobe", memStrobeCycles, 1);
  if (seenAddr !== modelAddr[3])
    reportMismatch("memAddr", seenAddr, modelAddr[3]);
  modelAddr[1]  = modelAddr[1] + 16'd1;
  modelCount[1] = modelCount[1] - 16'd1;
  modelAddr[3]  = modelAddr[3] - 16'd1;
  modelCount[3] = modelCount[3] - 16'd1;
  expectChannel(1);
  expectChannel(3);
  finishTest("priority, type and decrement");
endtask

task automatic terminalCountAutoInit();
  logic [dataWidth-1:0] status;
  errorsBeforeTest = errorCount;
  programChannel(0, modeByte(0, typeWrite, 1'b1, 1'b0), 16'h0000);
  programChannel(1, modeByte(1, typeWrite, 1'b0, 1'b0), 16'h0000);
  runTransfer(4'b0001);
  if (eopCycles != 1)
    reportCycles("eop on channel 0", eopCycles, 1);
  runTransfer(4'b0010);
  if (eopCycles != 1)
    reportCycles("eop on channel 1", eopCycles, 1);
  // with the controller disabled the request shows in status without a transfer
  cpuWrite(regCodeCommand, 8'(1 << cmdDisableBit));
  @(posedge busIf);
  dreq <= 4'b0001;
  cpuRead(regCodeStatus, status);
  if (status !== {4'b0001, 4'b0011})
    reportMismatch("dataOut, status", 16'(status), 16'h0013);
  cpuRead(regCodeStatus, status);
  if (status !== {4'b0001, 4'b0000})
    reportMismatch("dataOut, status after read", 16'(status), 16'h0010);
  @(posedge busIf);
  dreq <= '0;
  cpuWrite(regCodeCommand, 8'h00);
  // channel 0 reloads from base and channel 1 wraps
  modelAddr[1]  = modelAddr[1] + 16'd1;
  modelCount[1] = 16'hffff;
  expectChannel(0);
  expectChannel(1);
  finishTest("terminal count and autoinit");
endtask

task automatic disabledController();
  logic hrqSeen;
  errorsBeforeTest = errorCount;
  hrqSeen = 1'b0;
  cpuWrite(regCodeCommand, 8'(1 << cmdDisableBit));
  @(posedge busIf);
  dreq <= '1;
  repeat (20)
  begin
    @(negedge busIf);
    if (hrq)
      hrqSeen = 1'b1;
  end
  if (hrqSeen)
  begin
    $display("hrq rose while the controller was disabled");
    errorCount++;
  end
  @(posedge busIf);
  dreq <= '0;
  cpuWrite(regCodeCommand, 8'h00);
  finishTest("controller disable");
endtask

`endif

// File: bench/dmaTb.sv
`timescale 1ns/10ps

module dmaTb;

  import dmaPkg::*;

  localparam int clockPeriod = 20;
  localparam int resetCycles = 8;

  // cycle budget of each directed test
  localparam int budgetRegisters = 160;
  localparam int budgetPointer   = 40;
  localparam int budgetTiming    = 80;
  localparam int budgetPriority  = 120;
  localparam int budgetTerminal  = 160;
  localparam int budgetDisable   = 60;
  localparam int watchdogCycles  = 2 * (resetCycles + budgetRegisters + budgetPointer
                                   + budgetTiming + budgetPriority + budgetTerminal
                                   + budgetDisable);

  logic                 busIf;
  logic                 reset;
  logic                 csN;
  logic                 iorN;
  logic                 iowN;
  logic [3:0]           addrIn;
  logic [dataWidth-1:0] dataIn;
  logic [channels-1:0]  dreq;
  logic                 hlda;
  logic [dataWidth-1:0] dataOut;
  logic                 hrq;
  logic [channels-1:0]  dack;
  logic [addrWidth-1:0] memAddr;
  logic                 memrN;
  logic                 memwN;
  logic                 eop;

  integer seed = 32'he3d1_1ffb;
  int     errorCount;
  int     errorsBeforeTest;
  int     testsPassed;
  int     testsFailed;

  // expected contents of the current registers
  logic [addrWidth-1:0] modelAddr  [channels];
  logic [addrWidth-1:0] modelCount [channels];

  // pins as seen during the last transfer
  int                   grantToStrobe;
  int                   strobeCycles;
  int                   memStrobeCycles;
  int                   strobeToRelease;
  int                   eopCycles;
  logic [channels-1:0]  seenDack;
  logic [addrWidth-1:0] seenAddr;
  logic                 seenMemrN;
  logic                 seenMemwN;

  dmaController DUT (.*);

  `include "dmaTbTasks.svh"

  initial
  begin
    busIf = 1'b0;
    forever #(clockPeriod / 2) busIf = ~busIf;
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge busIf);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    reset  <= 1'b1;
    csN    <= 1'b1;
    iorN   <= 1'b1;
    iowN   <= 1'b1;
    addrIn <= '0;
    dataIn <= '0;
    dreq   <= '0;
    hlda   <= 1'b0;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    repeat (resetCycles) @(posedge busIf);
    reset <= 1'b0;
    @(posedge busIf);
    registerReadback();
    bytePointerClear();
    transferTiming();
    priorityAndDecrement();
    terminalCountAutoInit();
    disabledController();
    $display("tests passed %0d, tests failed %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+bench
hdl/dmaPkg.sv
hdl/dmaPortDecode.sv
hdl/dmaChannelRegisters.sv
hdl/dmaModeStatus.sv
hdl/dmaTimingFsm.sv
hdl/dmaTransferCounter.sv
hdl/dmaController.sv
bench/dmaTb.sv

// File: Makefile
# Verilator flow for the DMA controller testbench

TOP = dmaTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/10ps -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
